// ==== hw/agp_macros.svh ====
`ifndef AGP_MACROS_SVH
`define AGP_MACROS_SVH

`define AGP_WORD_W 32
`define AGP_ADR_W 5

// byte offsets on the slave port
`define AGP_REG_OPA 5'h00
`define AGP_REG_OPB 5'h04
`define AGP_REG_CMD 5'h08
`define AGP_REG_RESULT 5'h0C
`define AGP_REG_STATUS 5'h10

`define AGP_CMD_FUNC_LSB 0 // func in 3:0
`define AGP_CMD_UNIT_LSB 4 // unit in 5:4

`define AGP_STAT_BUSY 0
`define AGP_STAT_CARRY 1
`define AGP_STAT_OVF 2

`endif

// ==== hw/agp_pkg.sv ====
`include "agp_macros.svh"

package agp_pkg;

   typedef logic [`AGP_WORD_W-1:0] word_t;

   // same order as the processor's func field
   typedef enum logic [3:0] {
      ALU_ADD   = 4'd0,
      ALU_ADDC  = 4'd1,
      ALU_SUB   = 4'd2,
      ALU_CARRY = 4'd3,
      ALU_OVF   = 4'd4,
      ALU_INC   = 4'd5,
      ALU_DEC   = 4'd6,
      ALU_MUL   = 4'd7,
      ALU_MULHU = 4'd8,
      ALU_AND   = 4'd9,
      ALU_OR    = 4'd10,
      ALU_XOR   = 4'd11,
      ALU_EQ    = 4'd12,
      ALU_LESS  = 4'd13,
      ALU_LOWER = 4'd14,
      ALU_SND   = 4'd15
   } alu_func_e;

   typedef enum logic [1:0] {
      SH_LL  = 2'd0,
      SH_LR  = 2'd1,
      SH_AR  = 2'd2,
      SH_ROR = 2'd3
   } shift_func_e;

   typedef enum logic [1:0] {
      UNIT_ALU   = 2'd0,
      UNIT_SHIFT = 2'd1,
      UNIT_ACCEL = 2'd2,
      UNIT_RSVD  = 2'd3 // accepted, never started
   } exec_unit_e;

endpackage

// ==== hw/agp_accel.sv ====
`timescale 1ns/1ns
`include "agp_macros.svh"

module agp_accel import agp_pkg::*; (
   input  logic  clk,
   input  logic  arst_n,
   input  logic  start,
   input  word_t arg,
   output word_t result,
   output logic  done
);

   localparam int HALF_W = `AGP_WORD_W / 2;

   word_t             arg_q;
   logic [1:0]        step;     // 0 idle, then 1 and 2
   logic [HALF_W-1:0] half_sum; // carry out dropped

   assign half_sum = arg_q[`AGP_WORD_W-1:HALF_W] + arg_q[HALF_W-1:0];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         step <= 2'd0;
         done <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start) begin
            step <= 2'd1; // restarts a running sum too
         end else if (step == 2'd2) begin
            step <= 2'd0;
            done <= 1'b1;
         end else if (step != 2'd0) begin
            step <= step + 2'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         arg_q <= arg;
      end
      if (!start && step == 2'd2) begin
         result <= word_t'(half_sum);
      end
   end

endmodule

// ==== hw/agp_exec_unit.sv ====
`timescale 1ns/1ns
`include "agp_macros.svh"

module agp_exec_unit import agp_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       start,
   input  logic       shift_sel,
   input  logic [3:0] func,
   input  word_t      opa,
   input  word_t      opb,
   output word_t      result,
   output logic       done,
   output logic       carry,
   output logic       overflow
);

   localparam int W = `AGP_WORD_W;
   localparam int SH_W = $clog2(W);

   alu_func_e      alu_func;
   shift_func_e    shift_func;
   logic [W:0]     sum;
   word_t          diff;
   logic [2*W-1:0] prod;
   word_t          rot;
   word_t          alu_res;
   word_t          shift_res;
   logic           carry_nxt;
   logic           ovf_nxt;

   assign alu_func   = alu_func_e'(func);
   assign shift_func = shift_func_e'(func[1:0]);

   // add with carry shares the adder, old carry on the lsb
   assign sum  = {1'b0, opa} + {1'b0, opb} + {{W{1'b0}}, (alu_func == ALU_ADDC) & carry};
   assign diff = opa - opb;
   assign prod = {{W{1'b0}}, opa} * {{W{1'b0}}, opb};
   assign rot  = word_t'({opa, opa} >> opb[SH_W-1:0]); // amount mod word width

   always_comb begin
      alu_res   = '0;
      carry_nxt = carry;
      ovf_nxt   = overflow;
      case (alu_func)
         ALU_ADD: begin
            alu_res   = sum[W-1:0];
            carry_nxt = sum[W];
            ovf_nxt   = (opa[W-1] == opb[W-1]) && (sum[W-1] != opa[W-1]);
         end
         ALU_ADDC: begin
            alu_res   = sum[W-1:0];
            carry_nxt = sum[W];
         end
         ALU_SUB: begin
            alu_res = diff;
            ovf_nxt = (opa[W-1] != opb[W-1]) && (diff[W-1] != opa[W-1]);
         end
         // flags as they stood before this op
         ALU_CARRY: alu_res = word_t'(carry);
         ALU_OVF:   alu_res = word_t'(overflow);
         ALU_INC:   alu_res = opa + word_t'(1);
         ALU_DEC:   alu_res = opa - word_t'(1);
         ALU_MUL:   alu_res = prod[W-1:0];
         ALU_MULHU: alu_res = prod[2*W-1:W];
         ALU_AND:   alu_res = opa & opb;
         ALU_OR:    alu_res = opa | opb;
         ALU_XOR:   alu_res = opa ^ opb;
         ALU_EQ:    alu_res = word_t'(opa == opb);
         ALU_LESS:  alu_res = word_t'($signed(opa) < $signed(opb));
         ALU_LOWER: alu_res = word_t'(opa < opb);
         ALU_SND:   alu_res = opb;
      endcase
   end

   // full opb as amount, so logical shifts clear at 32 and up
   always_comb begin
      case (shift_func)
         SH_LL:  shift_res = opa << opb;
         SH_LR:  shift_res = opa >> opb;
         SH_AR:  shift_res = word_t'($signed(opa) >>> opb);
         SH_ROR: shift_res = rot;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         done     <= 1'b0;
         carry    <= 1'b0;
         overflow <= 1'b0;
      end else begin
         done <= start;
         if (start && !shift_sel) begin
            carry    <= carry_nxt;
            overflow <= ovf_nxt;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         result <= shift_sel ? shift_res : alu_res;
      end
   end

endmodule

// ==== hw/agp_exec_regs.sv ====
`timescale 1ns/1ns
`include "agp_macros.svh"

module agp_exec_regs import agp_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic [`AGP_ADR_W-1:0] wb_adr,
   input  word_t                 wb_wdata,
   output word_t                 wb_rdata,
   output logic                  wb_ack,
   output logic                  exec_start,
   output logic                  accel_start,
   output logic [3:0]            func,
   output logic                  shift_sel,
   output word_t                 opa,
   output word_t                 opb,
   input  word_t                 exec_result,
   input  logic                  exec_done,
   input  word_t                 accel_result,
   input  logic                  accel_done,
   input  logic                  carry,
   input  logic                  overflow
);

   logic       req;
   logic       cmd_sel;
   logic       stall;
   logic       acc;
   logic       wr;
   logic       busy;
   logic [3:0] cmd_func;
   exec_unit_e cmd_unit;
   exec_unit_e new_unit;
   word_t      result_q;
   word_t      cmd_word;
   word_t      status;

   assign req      = wb_cyc && wb_stb;
   assign cmd_sel  = (wb_adr == `AGP_REG_CMD);
   assign stall    = wb_we && cmd_sel && busy; // held off until busy drops
   assign acc      = req && !wb_ack && !stall; // no second ack for the same request
   assign wr       = acc && wb_we;
   assign new_unit = exec_unit_e'(wb_wdata[`AGP_CMD_UNIT_LSB +: 2]);

   assign func      = cmd_func;
   assign shift_sel = (cmd_unit == UNIT_SHIFT);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack <= 1'b0;
         opa    <= '0;
         opb    <= '0;
      end else begin
         wb_ack <= acc;
         if (wr) begin
            case (wb_adr)
               `AGP_REG_OPA: opa <= wb_wdata;
               `AGP_REG_OPB: opb <= wb_wdata;
               default: ; // cmd below, rest read only or unmapped
            endcase
         end
      end
   end

   // command issue and completion
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cmd_func    <= '0;
         cmd_unit    <= UNIT_ALU;
         busy        <= 1'b0;
         exec_start  <= 1'b0;
         accel_start <= 1'b0;
         result_q    <= '0;
      end else begin
         exec_start  <= 1'b0;
         accel_start <= 1'b0;
         if (wr && cmd_sel) begin
            cmd_func    <= wb_wdata[`AGP_CMD_FUNC_LSB +: 4];
            cmd_unit    <= new_unit;
            busy        <= (new_unit != UNIT_RSVD);
            exec_start  <= (new_unit == UNIT_ALU) || (new_unit == UNIT_SHIFT);
            accel_start <= (new_unit == UNIT_ACCEL);
         end
         if (exec_done || accel_done) begin
            busy <= 1'b0;
         end
         if (exec_done) begin
            result_q <= exec_result;
         end else if (accel_done) begin
            result_q <= accel_result;
         end
      end
   end

   always_comb begin
      cmd_word = '0;
      cmd_word[`AGP_CMD_FUNC_LSB +: 4] = cmd_func;
      cmd_word[`AGP_CMD_UNIT_LSB +: 2] = cmd_unit;

      status = '0;
      status[`AGP_STAT_BUSY]  = busy;
      status[`AGP_STAT_CARRY] = carry;
      status[`AGP_STAT_OVF]   = overflow;

      case (wb_adr)
         `AGP_REG_OPA:    wb_rdata = opa;
         `AGP_REG_OPB:    wb_rdata = opb;
         `AGP_REG_CMD:    wb_rdata = cmd_word;
         `AGP_REG_RESULT: wb_rdata = result_q;
         `AGP_REG_STATUS: wb_rdata = status;
         default:         wb_rdata = '0;
      endcase
   end

endmodule

// ==== hw/agp_exec_top.sv ====
`timescale 1ns/1ns
`include "agp_macros.svh"

module agp_exec_top import agp_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic [`AGP_ADR_W-1:0] wb_adr,
   input  word_t                 wb_wdata,
   output word_t                 wb_rdata,
   output logic                  wb_ack
);

   logic       exec_start;
   logic       accel_start;
   logic [3:0] func;
   logic       shift_sel;
   word_t      opa;
   word_t      opb;
   word_t      exec_result;
   logic       exec_done;
   word_t      accel_result;
   logic       accel_done;
   logic       carry;
   logic       overflow;

   agp_exec_regs u_regs (
      .clk          (clk),
      .arst_n       (arst_n),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_wdata     (wb_wdata),
      .wb_rdata     (wb_rdata),
      .wb_ack       (wb_ack),
      .exec_start   (exec_start),
      .accel_start  (accel_start),
      .func         (func),
      .shift_sel    (shift_sel),
      .opa          (opa),
      .opb          (opb),
      .exec_result  (exec_result),
      .exec_done    (exec_done),
      .accel_result (accel_result),
      .accel_done   (accel_done),
      .carry        (carry),
      .overflow     (overflow)
   );

   agp_exec_unit u_exec (
      .clk       (clk),
      .arst_n    (arst_n),
      .start     (exec_start),
      .shift_sel (shift_sel),
      .func      (func),
      .opa       (opa),
      .opb       (opb),
      .result    (exec_result),
      .done      (exec_done),
      .carry     (carry),
      .overflow  (overflow)
   );

   // accelerator only sees opa
   agp_accel u_accel (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (accel_start),
      .arg    (opa),
      .result (accel_result),
      .done   (accel_done)
   );

endmodule

// ==== verif/agp_exec_tb.sv ====
`timescale 1ns/1ns
`include "agp_macros.svh"

module agp_exec_tb import agp_pkg::*; ();

   localparam int TIMEOUT_CYCLES = 4000; // run is about 1400 cycles

   logic                  clk = 1'b0;
   logic                  arst_n;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   logic [`AGP_ADR_W-1:0] wb_adr;
   word_t                 wb_wdata;
   word_t                 wb_rdata;
   logic                  wb_ack;

   int   seed = 32'h33b118d3;
   int   n_pass = 0;
   int   n_fail = 0;
   int   pass_mark = 0;
   int   fail_mark = 0;
   int   cycle_cnt;
   int   shift_amts [5] = '{0, 5, 31, 32, 40};
   logic m_carry;
   logic m_ovf;

   always #5 clk = ~clk;

   agp_exec_top i_agp_exec_top (
      .clk      (clk),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_wdata (wb_wdata),
      .wb_rdata (wb_rdata),
      .wb_ack   (wb_ack)
   );

   task automatic check_val(input string name, input word_t got, input word_t exp);
      assert (got === exp) n_pass++;
      else begin
         $display("Error: %s got %h expected %h", name, got, exp);
         n_fail++;
      end
   endtask

   task automatic end_test(input string name);
      $display("%s: %0d checks, %0d failed", name,
               (n_pass - pass_mark) + (n_fail - fail_mark), n_fail - fail_mark);
      pass_mark = n_pass;
      fail_mark = n_fail;
   endtask

   // one classic cycle with ack and read data sampled on the falling edge
   task automatic bus_cycle(input logic we, input logic [`AGP_ADR_W-1:0] adr,
                            input word_t wdata, output word_t rdata, output int waits);
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_wdata <= wdata;
      waits = 0;
      do begin
         @(negedge clk);
         waits++;
      end while (!wb_ack);
      rdata = wb_rdata;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic write_reg(input logic [`AGP_ADR_W-1:0] adr, input word_t data);
      word_t rd_ignored;
      int    waits;
      bus_cycle(1'b1, adr, data, rd_ignored, waits);
   endtask

   task automatic read_reg(input logic [`AGP_ADR_W-1:0] adr, output word_t data);
      int waits;
      bus_cycle(1'b0, adr, '0, data, waits);
   endtask

   task automatic wait_idle(output word_t st, output int polls);
      polls = 0;
      do begin
         read_reg(`AGP_REG_STATUS, st);
         polls++;
      end while (st[`AGP_STAT_BUSY]);
   endtask

   function automatic word_t cmd_word(input exec_unit_e unit, input logic [3:0] fn);
      word_t w;
      w = '0;
      w[`AGP_CMD_UNIT_LSB +: 2] = unit;
      w[`AGP_CMD_FUNC_LSB +: 4] = fn;
      return w;
   endfunction

   function automatic word_t status_ref();
      word_t s;
      s = '0;
      s[`AGP_STAT_CARRY] = m_carry;
      s[`AGP_STAT_OVF]   = m_ovf;
      return s;
   endfunction

   // reference ALU that also keeps m_carry and m_ovf
   task automatic alu_ref(input logic [3:0] fn, input word_t a, input word_t b,
                          output word_t res);
      logic [32:0] s;
      logic [63:0] p;
      s = {1'b0, a} + {1'b0, b};
      p = {32'h0, a} * {32'h0, b};
      res = '0;
      case (alu_func_e'(fn))
         ALU_ADD: begin
            res     = s[31:0];
            m_carry = s[32];
            m_ovf   = (a[31] == b[31]) && (res[31] != a[31]);
         end
         ALU_ADDC: begin
            s       = s + {32'h0, m_carry};
            res     = s[31:0];
            m_carry = s[32];
         end
         ALU_SUB: begin
            res   = a - b;
            m_ovf = (a[31] != b[31]) && (res[31] != a[31]);
         end
         ALU_CARRY: res = {31'h0, m_carry};
         ALU_OVF:   res = {31'h0, m_ovf};
         ALU_INC:   res = a + 32'd1;
         ALU_DEC:   res = a - 32'd1;
         ALU_MUL:   res = p[31:0];
         ALU_MULHU: res = p[63:32];
         ALU_AND:   res = a & b;
         ALU_OR:    res = a | b;
         ALU_XOR:   res = a ^ b;
         ALU_EQ:    res = {31'h0, a == b};
         ALU_LESS:  res = {31'h0, $signed(a) < $signed(b)};
         ALU_LOWER: res = {31'h0, a < b};
         ALU_SND:   res = b;
      endcase
   endtask

   function automatic word_t shift_ref(input logic [1:0] fn, input word_t a, input word_t b);
      int unsigned n;
      n = b % 32;
      case (shift_func_e'(fn))
         SH_LL:   return (b >= 32) ? '0 : a << b;
         SH_LR:   return (b >= 32) ? '0 : a >> b;
         SH_AR:   return (b >= 32) ? {32{a[31]}} : word_t'($signed(a) >>> b);
         default: return (n == 0) ? a : (a >> n) | (a << (32 - n));
      endcase
   endfunction

   function automatic word_t accel_ref(input word_t a);
      logic [15:0] h;
      h = a[31:16] + a[15:0]; // carry out lost
      return {16'h0, h};
   endfunction

   // writes operands and command, polls, then checks status and result
   task automatic run_op(input exec_unit_e unit, input logic [3:0] fn,
                         input word_t a, input word_t b);
      word_t exp;
      word_t got;
      word_t st;
      int    polls;
      case (unit)
         UNIT_SHIFT: exp = shift_ref(fn[1:0], a, b);
         UNIT_ACCEL: exp = accel_ref(a);
         default:    alu_ref(fn, a, b, exp);
      endcase
      write_reg(`AGP_REG_OPA, a);
      write_reg(`AGP_REG_OPB, b);
      write_reg(`AGP_REG_CMD, cmd_word(unit, fn));
      wait_idle(st, polls);
      check_val("STATUS polls", word_t'(polls), (unit == UNIT_ACCEL) ? 32'd2 : 32'd1);
      check_val("STATUS", st, status_ref());
      read_reg(`AGP_REG_RESULT, got);
      check_val($sformatf("RESULT unit %0d func %0d", unit, fn), got, exp);
   endtask

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("run stopped, no end after %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      word_t a;
      word_t b;
      word_t rd;
      word_t exp;
      int    waits;
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
      wb_adr   <= '0;
      wb_wdata <= '0;
      arst_n   <= 1'b0;
      m_carry = 1'b0;
      m_ovf   = 1'b0;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;

      read_reg(`AGP_REG_OPA, rd);
      check_val("OPA", rd, 32'h0);
      read_reg(`AGP_REG_OPB, rd);
      check_val("OPB", rd, 32'h0);
      read_reg(`AGP_REG_RESULT, rd);
      check_val("RESULT", rd, 32'h0);
      read_reg(`AGP_REG_STATUS, rd);
      check_val("STATUS", rd, 32'h0);
      end_test("reset values");

      for (int f = 0; f < 16; f++) begin
         a = $random(seed);
         b = $random(seed);
         run_op(UNIT_ALU, 4'(f), a, b);
      end
      run_op(UNIT_ALU, ALU_EQ, a, a); // equal operands are rare with random data
      end_test("alu functions");

      run_op(UNIT_ALU, ALU_ADD, 32'hffff_ffff, 32'h1);
      run_op(UNIT_ALU, ALU_CARRY, 32'h0, 32'h0);
      run_op(UNIT_ALU, ALU_ADDC, 32'h1, 32'h2);
      run_op(UNIT_ALU, ALU_ADD, 32'h7fff_ffff, 32'h1); // signed overflow
      run_op(UNIT_ALU, ALU_OVF, 32'h0, 32'h0);
      run_op(UNIT_ALU, ALU_SUB, 32'h8000_0000, 32'h1);
      run_op(UNIT_ALU, ALU_SUB, 32'h5, 32'h3);
      run_op(UNIT_ALU, ALU_OVF, 32'h0, 32'h0);
      for (int i = 0; i < 12; i++) begin
         a = $random(seed);
         b = $random(seed);
         run_op(UNIT_ALU, 4'($unsigned($random(seed)) % 5), a, b); // add..ovf only
      end
      end_test("flags");

      for (int s = 0; s < 2; s++) begin
         for (int k = 0; k < 5; k++) begin
            for (int f = 0; f < 4; f++) begin
               a = $random(seed);
               a[31] = s[0];
               run_op(UNIT_SHIFT, 4'(f), a, word_t'(shift_amts[k]));
            end
         end
      end
      end_test("shifts");

      run_op(UNIT_ACCEL, 4'h0, 32'hffff_ffff, 32'h0);
      for (int i = 0; i < 6; i++) begin
         a = $random(seed);
         run_op(UNIT_ACCEL, 4'h0, a, 32'h0);
      end
      end_test("accelerator");

      a = $random(seed);
      b = $random(seed);
      write_reg(`AGP_REG_OPA, a);
      write_reg(`AGP_REG_OPB, b);
      write_reg(`AGP_REG_CMD, cmd_word(UNIT_ACCEL, 4'h0));
      // second command right behind the accel run is held until busy drops
      bus_cycle(1'b1, `AGP_REG_CMD, cmd_word(UNIT_ALU, ALU_SUB), rd, waits);
      check_val("CMD ack wait", word_t'(waits), 32'd4);
      alu_ref(ALU_SUB, a, b, exp);
      wait_idle(rd, waits);
      check_val("STATUS", rd, status_ref());
      read_reg(`AGP_REG_RESULT, rd);
      check_val("RESULT", rd, exp);
      end_test("back-pressure");

      write_reg(`AGP_REG_CMD, cmd_word(UNIT_RSVD, ALU_XOR));
      read_reg(`AGP_REG_STATUS, rd);
      check_val("STATUS", rd, status_ref()); // busy low and flags untouched
      read_reg(`AGP_REG_CMD, rd);
      check_val("CMD", rd, cmd_word(UNIT_RSVD, ALU_XOR));
      read_reg(`AGP_REG_RESULT, rd);
      check_val("RESULT", rd, exp);
      end_test("reserved unit");

      $display("checks passed %0d, failed %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+hw
hw/agp_pkg.sv
hw/agp_accel.sv
hw/agp_exec_unit.sv
hw/agp_exec_regs.sv
hw/agp_exec_top.sv
verif/agp_exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= agp_exec_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ns

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "no result line in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
